// ==== hdl/lcd_cfg.svh ====
// LCD panel configuration
// display geometry, character codes, controller commands and enable timing
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// geometry of the 16x2 character display
`define LCD_COLS 16
`define SHOW_BITS 14

// characters used for the monitor bit fields
`define CHAR_ONE 8'h31
`define CHAR_ZERO 8'h30

// set-DDRAM-address commands for the start of each line
`define CMD_LINE1 8'h80
`define CMD_LINE2 8'hC0

// enable strobe timing in clock cycles
// short for simulation and raised for board builds
`define EN_HIGH_CYCLES 4
`define EN_GAP_CYCLES 4

`endif

// ==== hdl/lcdPkg.sv ====
// LCD panel shared types
// byte, step, cursor and screen types plus the FSM state encodings
`include "lcd_cfg.svh"

package lcdPkg;

	typedef logic [7:0] charT; // one character or command byte
	typedef logic [`SHOW_BITS-1:0] showBitsT; // monitor line value
	typedef logic [3:0] cfgStepT; // console configuration step
	typedef logic [4:0] cursorT; // 0-15 line 1, 16-31 line 2

	typedef enum logic [3:0]
	{
		scrStart,
		scrSelMaster,
		scrSelSlave,
		scrAddr,
		scrData,
		scrBursts,
		scrSave,
		scrMonitor,
		scrDone
	} screenT;

	typedef enum logic [1:0] {seqCmd, seqChar, seqWaitAck, seqWaitRelease} seqStateT;

	typedef enum logic [1:0] {stbIdle, stbHigh, stbGap, stbAck} strobeStateT;

endpackage

// ==== hdl/lcdByteIf.sv ====
// LCD byte handshake
// four-phase req/ack transfer of one byte and its RS level
interface lcdByteIf;

	logic req; // byte valid, held until ack
	lcdPkg::charT byteVal;
	logic isData; // RS level, high for characters
	logic ack; // raised once the strobe is done

	modport seqSide
	(
		output req, byteVal, isData,
		input ack
	);

	modport strobeSide
	(
		input req, byteVal, isData,
		output ack
	);

endinterface

// ==== hdl/screenSelect.sv ====
// Screen select
// keeps the configuration-done flag and picks one of the nine screens
module screenSelect
(
	input logic clock,
	input logic rst,
	input logic modeSwitch, // 1 = monitor, 0 = configure
	input lcdPkg::cfgStepT cfgStep,
	output lcdPkg::screenT screen
);

	logic cfgDone;
	lcdPkg::screenT screenNext;

	always_comb
	begin
		if (modeSwitch)
			screenNext = lcdPkg::scrMonitor;
		else
		begin
			case (cfgStep)
				4'd0: screenNext = cfgDone ? lcdPkg::scrDone : lcdPkg::scrStart;
				4'd1: screenNext = lcdPkg::scrSelMaster;
				4'd2: screenNext = lcdPkg::scrSelSlave;
				4'd3: screenNext = lcdPkg::scrAddr;
				4'd4: screenNext = lcdPkg::scrData;
				4'd5: screenNext = lcdPkg::scrBursts;
				4'd6: screenNext = lcdPkg::scrSave;
				default: screenNext = lcdPkg::scrStart; // unused steps
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rst)
		begin
			cfgDone <= 1'b0;
			screen <= lcdPkg::scrStart;
		end
		else
		begin
			if (!modeSwitch && cfgStep == 4'd6)
				cfgDone <= 1'b1; // save step reached
			else if (modeSwitch)
				cfgDone <= 1'b0;
			screen <= screenNext;
		end
	end

endmodule

// ==== hdl/messageRom.sv ====
// Message ROM
// character lookup for every screen, including the monitor bit display
`include "lcd_cfg.svh"

module messageRom
(
	input lcdPkg::screenT screen,
	input lcdPkg::cursorT cursor,
	input lcdPkg::showBitsT dataLine1,
	input lcdPkg::showBitsT dataLine2,
	output lcdPkg::charT charOut
);

	localparam logic [`LCD_COLS*8-1:0] blankLine = "                ";
	localparam logic [`LCD_COLS*8-1:0] startL1 = "Start Config    ";
	localparam logic [`LCD_COLS*8-1:0] startL2 = "Press Any Key   ";
	localparam logic [`LCD_COLS*8-1:0] masterL1 = "Select Master   ";
	localparam logic [`LCD_COLS*8-1:0] slaveL1 = "Select Slave    ";
	localparam logic [`LCD_COLS*8-1:0] addrL1 = "Input Address   ";
	localparam logic [`LCD_COLS*8-1:0] addrL2 = "SW[0:11]        ";
	localparam logic [`LCD_COLS*8-1:0] dataL1 = "Input Data      ";
	localparam logic [`LCD_COLS*8-1:0] dataL2 = "SW[0:7]         ";
	localparam logic [`LCD_COLS*8-1:0] burstL1 = "Input Number of ";
	localparam logic [`LCD_COLS*8-1:0] burstL2 = "Bursts          ";
	localparam logic [`LCD_COLS*8-1:0] saveL1 = "Save Config     ";
	localparam logic [`LCD_COLS*8-1:0] doneL1 = "Config Done     ";
	localparam logic [`LCD_COLS*8-1:0] doneL2 = "Start New Config";

	logic lineTwo;
	logic [3:0] col;
	logic [3:0] bitSel;
	logic [`LCD_COLS*8-1:0] lineText;
	lcdPkg::showBitsT showBits;
	lcdPkg::charT textChar;
	lcdPkg::charT monChar;

	assign lineTwo = cursor[4];
	assign col = cursor[3:0];
	assign showBits = lineTwo ? dataLine2 : dataLine1;
	assign bitSel = 4'(`SHOW_BITS + 1) - col; // col 2 shows bit 13, col 15 bit 0

	always_comb
	begin
		case (screen)
			lcdPkg::scrStart: lineText = lineTwo ? startL2 : startL1;
			lcdPkg::scrSelMaster: lineText = lineTwo ? blankLine : masterL1;
			lcdPkg::scrSelSlave: lineText = lineTwo ? blankLine : slaveL1;
			lcdPkg::scrAddr: lineText = lineTwo ? addrL2 : addrL1;
			lcdPkg::scrData: lineText = lineTwo ? dataL2 : dataL1;
			lcdPkg::scrBursts: lineText = lineTwo ? burstL2 : burstL1;
			lcdPkg::scrSave: lineText = lineTwo ? blankLine : saveL1;
			lcdPkg::scrDone: lineText = lineTwo ? doneL2 : doneL1;
			default: lineText = blankLine; // monitor is built below
		endcase
	end

	// leftmost character sits in the top byte of the literal
	assign textChar = lineText[(`LCD_COLS - 1 - col) * 8 +: 8];

	always_comb
	begin
		if (col == 4'd0)
			monChar = lineTwo ? 8'h44 : 8'h41; // D or A
		else if (col == 4'd1)
			monChar = 8'h2D; // dash
		else
			monChar = showBits[bitSel] ? `CHAR_ONE : `CHAR_ZERO;
	end

	assign charOut = (screen == lcdPkg::scrMonitor) ? monChar : textChar;

endmodule

// ==== hdl/refreshSequencer.sv ====
// Refresh sequencer
// walks each 34-byte frame (line command, 16 characters, twice) without end
// and hands every byte to the bus strobe over the req/ack handshake
`include "lcd_cfg.svh"

module refreshSequencer
(
	input logic clock,
	input logic rst,
	output lcdPkg::cursorT cursor,
	input lcdPkg::charT charIn,
	lcdByteIf.seqSide busOut
);

	lcdPkg::seqStateT state;

	always_ff @(posedge clock)
	begin
		if (!rst)
		begin
			state <= lcdPkg::seqCmd;
			cursor <= '0;
			busOut.req <= 1'b0;
			busOut.isData <= 1'b0;
		end
		else
		begin
			case (state)
				lcdPkg::seqCmd:
				begin
					busOut.req <= 1'b1;
					busOut.isData <= 1'b0; // RS low for commands
					state <= lcdPkg::seqWaitAck;
				end
				lcdPkg::seqChar:
				begin
					busOut.req <= 1'b1;
					busOut.isData <= 1'b1;
					state <= lcdPkg::seqWaitAck;
				end
				lcdPkg::seqWaitAck:
				begin
					if (busOut.ack) // stall here until the strobe finishes
					begin
						busOut.req <= 1'b0;
						state <= lcdPkg::seqWaitRelease;
					end
				end
				default:
				begin
					if (!busOut.ack)
					begin
						if (!busOut.isData)
							state <= lcdPkg::seqChar; // the character follows its command
						else
						begin
							cursor <= cursor + 5'd1; // wraps to line 1 after 31
							if (cursor[3:0] == 4'(`LCD_COLS - 1))
								state <= lcdPkg::seqCmd;
							else
								state <= lcdPkg::seqChar;
						end
					end
				end
			endcase
		end
	end

	// byte is loaded in the cycle that raises req
	always_ff @(posedge clock)
	begin
		if (state == lcdPkg::seqCmd)
			busOut.byteVal <= cursor[4] ? `CMD_LINE2 : `CMD_LINE1;
		else if (state == lcdPkg::seqChar)
			busOut.byteVal <= charIn;
	end

endmodule

// ==== hdl/busStrobe.sv ====
// Bus strobe
// puts each handshaked byte on the LCD pins, pulses enable, waits out the gap
// and then acknowledges
`include "lcd_cfg.svh"

module busStrobe
(
	input logic clock,
	input logic rst,
	lcdByteIf.strobeSide busIn,
	output logic lcdEn,
	output logic lcdRs,
	output lcdPkg::charT lcdData
);

	localparam int cntMax = (`EN_HIGH_CYCLES > `EN_GAP_CYCLES) ? `EN_HIGH_CYCLES : `EN_GAP_CYCLES;
	localparam int cntWidth = $clog2(cntMax + 1);

	lcdPkg::strobeStateT state;
	logic [cntWidth-1:0] cnt;

	always_ff @(posedge clock)
	begin
		if (!rst)
		begin
			state <= lcdPkg::stbIdle;
			cnt <= '0;
			lcdEn <= 1'b0;
			busIn.ack <= 1'b0;
		end
		else
		begin
			case (state)
				lcdPkg::stbIdle:
				begin
					if (busIn.req)
					begin
						lcdEn <= 1'b1;
						cnt <= '0;
						state <= lcdPkg::stbHigh;
					end
				end
				lcdPkg::stbHigh:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == cntWidth'(`EN_HIGH_CYCLES - 1))
					begin
						lcdEn <= 1'b0; // LCD latches on this falling edge
						cnt <= '0;
						state <= lcdPkg::stbGap;
					end
				end
				lcdPkg::stbGap:
				begin
					cnt <= cnt + 1'b1;
					if (cnt == cntWidth'(`EN_GAP_CYCLES - 1))
					begin
						busIn.ack <= 1'b1;
						state <= lcdPkg::stbAck;
					end
				end
				default:
				begin
					if (!busIn.req) // sequencer released
					begin
						busIn.ack <= 1'b0;
						state <= lcdPkg::stbIdle;
					end
				end
			endcase
		end
	end

	// pins only change when a new byte is taken, so they hold until ack falls
	always_ff @(posedge clock)
	begin
		if (state == lcdPkg::stbIdle && busIn.req)
		begin
			lcdData <= busIn.byteVal;
			lcdRs <= busIn.isData;
		end
	end

endmodule

// ==== hdl/lcdPanel.sv ====
// LCD status panel
// screen select, message ROM and the refresh driver for a 16x2 character LCD
module lcdPanel
(
	input logic clock,
	input logic rst,
	input logic modeSwitch,
	input lcdPkg::cfgStepT configState,
	input lcdPkg::showBitsT dataLine1,
	input lcdPkg::showBitsT dataLine2,
	output logic lcdEn,
	output logic lcdRs, // 0 = command, 1 = data
	output lcdPkg::charT lcdData
);

	lcdPkg::screenT screen;
	lcdPkg::cursorT cursor;
	lcdPkg::charT charVal;

	lcdByteIf byteBus();

	screenSelect screenSel_i
	(
		.clock(clock),
		.rst(rst),
		.modeSwitch(modeSwitch),
		.cfgStep(configState),
		.screen(screen)
	);

	messageRom messageRom_i
	(
		.screen(screen),
		.cursor(cursor),
		.dataLine1(dataLine1),
		.dataLine2(dataLine2),
		.charOut(charVal)
	);

	refreshSequencer refreshSeq_i
	(
		.clock(clock),
		.rst(rst),
		.cursor(cursor),
		.charIn(charVal),
		.busOut(byteBus.seqSide)
	);

	busStrobe busStrobe_i
	(
		.clock(clock),
		.rst(rst),
		.busIn(byteBus.strobeSide),
		.lcdEn(lcdEn),
		.lcdRs(lcdRs),
		.lcdData(lcdData)
	);

endmodule

// ==== bench/lcdPanel_props.sv ====
// LCD bus strobe assertions
// enable after reset, pin stability during the pulse and req/ack ordering
module lcdPanel_props
(
	input logic clock,
	input logic rst,
	input logic lcdEn,
	input logic lcdRs,
	input lcdPkg::charT lcdData,
	input logic req,
	input logic ack
);

	timeunit 1ns;
	timeprecision 1ps;

	int assertFails = 0; // failed assertion count

	enLowAfterReset: assert property (@(posedge clock) !rst |=> !lcdEn)
		else
		begin
			assertFails++;
			$error("lcdEn is high after reset");
		end

	// covers the cycle of the falling edge too
	pinsStable: assert property (@(posedge clock) disable iff (!rst)
		$past(lcdEn) |-> $stable(lcdData) && $stable(lcdRs))
		else
		begin
			assertFails++;
			$error("LCD pins changed while enable was high");
		end

	ackNeedsReq: assert property (@(posedge clock) disable iff (!rst) $rose(ack) |-> req)
		else
		begin
			assertFails++;
			$error("ack rose without req");
		end

	reqHeldForAck: assert property (@(posedge clock) disable iff (!rst) $fell(req) |-> ack)
		else
		begin
			assertFails++;
			$error("req fell before ack");
		end

endmodule

bind busStrobe lcdPanel_props props_i
(
	.clock(clock),
	.rst(rst),
	.lcdEn(lcdEn),
	.lcdRs(lcdRs),
	.lcdData(lcdData),
	.req(busIn.req),
	.ack(busIn.ack)
);

// ==== bench/lcdPanel_tb.sv ====
// LCD panel testbench
// drives the settings of each vector line, captures the refreshed frame at
// every enable falling edge and compares it with the expected screen text
`include "lcd_cfg.svh"

module lcdPanel_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int maxTests = 32;
	localparam int byteTimeout = 60; // cycles allowed per strobe
	localparam int syncTimeout = 40; // bytes allowed before a frame start
	localparam int frameBytes = 34;

	logic clock;
	logic rst;
	logic modeSwitch;
	lcdPkg::cfgStepT configState;
	lcdPkg::showBitsT dataLine1;
	lcdPkg::showBitsT dataLine2;
	logic lcdEn;
	logic lcdRs;
	lcdPkg::charT lcdData;

	logic [127:0] vecMem [0:6*maxTests-1]; // six words per test
	int testCount;
	int passCount;
	int failCount;
	bit aborted;

	lcdPanel dut_i
	(
		.clock(clock),
		.rst(rst),
		.modeSwitch(modeSwitch),
		.configState(configState),
		.dataLine1(dataLine1),
		.dataLine2(dataLine2),
		.lcdEn(lcdEn),
		.lcdRs(lcdRs),
		.lcdData(lcdData)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// returns the byte latched by the next enable falling edge
	task automatic nextByte(output lcdPkg::charT data, output logic rs);
		int waited;
		logic prevEn;
		bit seen;
		prevEn = lcdEn;
		waited = 0;
		seen = 1'b0;
		data = '0;
		rs = 1'b0;
		while (!seen && waited < byteTimeout)
		begin
			@(negedge clock);
			if (prevEn && !lcdEn)
			begin
				data = lcdData;
				rs = lcdRs;
				seen = 1'b1;
			end
			prevEn = lcdEn;
			waited++;
		end
		if (!seen)
		begin
			$display("timeout: no enable strobe within %0d cycles", byteTimeout);
			aborted = 1'b1;
		end
	endtask

	// consumes bytes up to and including the next line-1 command
	task automatic syncFrame();
		lcdPkg::charT data;
		logic rs;
		int count;
		bit found;
		count = 0;
		found = 1'b0;
		while (!found && !aborted && count < syncTimeout)
		begin
			nextByte(data, rs);
			if (!aborted && !rs && data == `CMD_LINE1)
				found = 1'b1;
			count++;
		end
		if (!found && !aborted)
		begin
			$display("no line-1 command seen within %0d bytes", syncTimeout);
			aborted = 1'b1;
		end
	endtask

	function automatic lcdPkg::charT textChar(logic [127:0] lineText, int col);
		return lineText[(15 - col) * 8 +: 8]; // first character in the top byte
	endfunction

	task automatic finishTest(int num, int errors);
		if (aborted)
		begin
			$display("test %0d: aborted", num);
			failCount++;
		end
		else if (errors == 0)
		begin
			$display("test %0d: ok", num);
			passCount++;
		end
		else
		begin
			$display("test %0d: %0d mismatches", num, errors);
			failCount++;
		end
		testCount++;
	endtask

	task automatic checkReset();
		lcdPkg::charT data;
		logic rs;
		int errors;
		errors = 0;
		if (lcdEn !== 1'b0)
		begin
			$display("Fail test 0 lcdEn after reset: expected 0, got %h", lcdEn);
			errors++;
		end
		nextByte(data, rs);
		if (!aborted && data !== `CMD_LINE1)
		begin
			$display("Fail test 0 lcdData byte 0: expected %h, got %h", `CMD_LINE1, data);
			errors++;
		end
		if (!aborted && rs !== 1'b0)
		begin
			$display("Fail test 0 lcdRs byte 0: expected 0, got %h", rs);
			errors++;
		end
		finishTest(0, errors);
	endtask

	task automatic runTest(input int num,
		input logic [127:0] mode, step, d1, d2, line1, line2);
		lcdPkg::charT data;
		lcdPkg::charT expData;
		logic rs;
		logic expRs;
		int errors;
		errors = 0;
		@(negedge clock);
		modeSwitch = mode[0];
		configState = step[3:0];
		dataLine1 = d1[13:0]; // bits 15:14 have no pin
		dataLine2 = d2[13:0];
		syncFrame(); // this frame may still mix old and new settings
		syncFrame();
		for (int pos = 1; pos < frameBytes && !aborted; pos++)
		begin
			nextByte(data, rs);
			expRs = (pos != 17);
			if (pos == 17)
				expData = `CMD_LINE2;
			else if (pos < 17)
				expData = textChar(line1, pos - 1);
			else
				expData = textChar(line2, pos - 18);
			if (!aborted && data !== expData)
			begin
				$display("Fail test %0d lcdData byte %0d: expected %h, got %h",
					num, pos, expData, data);
				errors++;
			end
			if (!aborted && rs !== expRs)
			begin
				$display("Fail test %0d lcdRs byte %0d: expected %h, got %h", num, pos, expRs, rs);
				errors++;
			end
		end
		finishTest(num, errors);
	endtask

	initial
	begin
		int idx;
		rst = 1'b0;
		modeSwitch = 1'b0;
		configState = '0;
		dataLine1 = '0;
		dataLine2 = '0;
		testCount = 0;
		passCount = 0;
		failCount = 0;
		aborted = 1'b0;
		idx = 0;
		for (int i = 0; i < 6 * maxTests; i++)
			vecMem[i] = '1; // marks entries past the last vector
		$readmemh("bench/lcdPanel_vectors.txt", vecMem);
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst = 1'b1;
		checkReset();
		while (!aborted && idx < maxTests && vecMem[6*idx] !== '1)
		begin
			runTest(idx + 1, vecMem[6*idx], vecMem[6*idx+1], vecMem[6*idx+2],
				vecMem[6*idx+3], vecMem[6*idx+4], vecMem[6*idx+5]);
			idx++;
		end
		if (idx == 0)
			$display("no test vectors found in the vector file");
		if (dut_i.busStrobe_i.props_i.assertFails != 0)
			$display("%0d bus assertions failed", dut_i.busStrobe_i.props_i.assertFails);
		$display("%0d tests, %0d passed, %0d failed", testCount, passCount, failCount);
		if (failCount == 0 && !aborted && idx > 0
			&& dut_i.busStrobe_i.props_i.assertFails == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== bench/lcdPanel_vectors.txt ====
// modeSwitch configState dataLine1 dataLine2 line1 line2, all hex
// line1 and line2 hold the 16 expected characters of each display line
0 0 0000 0000 537461727420436f6e66696720202020 507265737320416e79204b6579202020
0 1 0000 0000 53656c656374204d6173746572202020 20202020202020202020202020202020
0 2 0000 0000 53656c65637420536c61766520202020 20202020202020202020202020202020
0 3 0000 0000 496e7075742041646472657373202020 53575b303a31315d2020202020202020
0 4 0000 0000 496e7075742044617461202020202020 53575b303a375d202020202020202020
0 5 0000 0000 496e707574204e756d626572206f6620 42757273747320202020202020202020
0 6 0000 0000 5361766520436f6e6669672020202020 20202020202020202020202020202020
0 0 0000 0000 436f6e66696720446f6e652020202020 5374617274204e657720436f6e666967
0 9 0000 0000 537461727420436f6e66696720202020 507265737320416e79204b6579202020
1 0 2aaa 1555 412d3130313031303130313031303130 442d3031303130313031303130313031
1 3 c000 ffff 412d3030303030303030303030303030 442d3131313131313131313131313131
1 0 4001 8123 412d3030303030303030303030303031 442d3030303030313030313030303131
0 0 0000 0000 537461727420436f6e66696720202020 507265737320416e79204b6579202020

// ==== verilog.f ====
+incdir+hdl
hdl/lcdPkg.sv
hdl/lcdByteIf.sv
hdl/screenSelect.sv
hdl/messageRom.sv
hdl/refreshSequencer.sv
hdl/busStrobe.sv
hdl/lcdPanel.sv
bench/lcdPanel_props.sv
bench/lcdPanel_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP = lcdPanel_tb
FILELIST = verilog.f
BUILD_DIR = obj_dir
LOG = sim.log
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove build output and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
